//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/lsu_pkg.sv
      - logic/lsu_stage_if.sv
      - logic/lsu_cfg_regs.sv
      - logic/lsu_addr_stage.sv
      - logic/lsu_dccm.sv
      - logic/lsu_result_stage.sv
      - logic/lsu_top.sv
  - target: test
    include_dirs:
      - logic
      - tb
    files:
      - tb/lsu_tb.sv

//--- filelist.f
+incdir+logic
+incdir+tb
logic/lsu_pkg.sv
logic/lsu_stage_if.sv
logic/lsu_cfg_regs.sv
logic/lsu_addr_stage.sv
logic/lsu_dccm.sv
logic/lsu_result_stage.sv
logic/lsu_top.sv
tb/lsu_tb.sv

//--- logic/lsu_addr_stage.sv
// LSU address stage: effective address, fault classification and the M-stage register
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_addr_stage (
   input  wire                     clk,
   input  wire                     arst_n,
   input  wire                     req_valid,
   input  wire                     req_store,
   input  wire                     req_unsigned,
   input  wire lsu_pkg::lsu_size_t   req_size,
   input  wire lsu_pkg::lsu_word_t   req_rs1,
   input  wire lsu_pkg::lsu_word_t   req_wdata,
   input  wire lsu_pkg::lsu_offset_t req_offset,
   input  wire lsu_pkg::lsu_word_t   dccm_base,
   lsu_stage_if.src                m,
   output logic                    m_busy
);
   import lsu_pkg::*;

   lsu_word_t  eff_addr;       // rs1 + sign extended offset
   lsu_word_t  rel_addr;       // Byte offset into the DCCM window
   logic       out_of_range;
   logic       bad_store;      // Sub-word stores are not supported
   logic       misaligned;
   lsu_cause_t cause_d;

   // ************************************************************************
   // Address and fault checks
   // ************************************************************************
   assign eff_addr = req_rs1 +
                     {{(32-`LSU_OFFSET_W){req_offset[`LSU_OFFSET_W-1]}}, req_offset};
   assign rel_addr = eff_addr - dccm_base;   // Wraps below base, so one compare

   assign out_of_range = (rel_addr >= 32'(4 * `LSU_DCCM_WORDS));
   assign bad_store    = req_store && (req_size != LSU_SIZE_WORD);
   assign misaligned   = ((req_size == LSU_SIZE_HALF) && eff_addr[0]) ||
                         ((req_size == LSU_SIZE_WORD) && (eff_addr[1:0] != 2'b00));

   // Range first, then store size, then alignment
   always_comb begin
      if (out_of_range)    cause_d = LSU_CAUSE_RANGE;
      else if (bad_store)  cause_d = LSU_CAUSE_STORE_SIZE;
      else if (misaligned) cause_d = LSU_CAUSE_MISALIGNED;
      else                 cause_d = LSU_CAUSE_NONE;
   end

   // ************************************************************************
   // M-stage register
   // ************************************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) m.valid <= 1'b0;
      else         m.valid <= req_valid;   // No stall, one per cycle
   end

   // Descriptor only loads with a request
   always_ff @(posedge clk) begin
      if (req_valid) begin
         m.store       <= req_store;
         m.unsigned_ld <= req_unsigned;
         m.size        <= req_size;
         m.byte_off    <= eff_addr[1:0];
         m.idx         <= rel_addr[`LSU_DCCM_ADDR_W+1:2];
         m.wdata       <= req_wdata;
         m.cause       <= cause_d;
      end
   end

   assign m_busy = m.valid;

   // A store held in M without a cause is a word store on a word boundary
   a_fault_reaches_m: assert property (@(posedge clk) disable iff (!arst_n)
      (m.valid && m.store && m.cause == LSU_CAUSE_NONE)
      |-> (m.size == LSU_SIZE_WORD && m.byte_off == 2'b00));

endmodule

`default_nettype wire

//--- logic/lsu_cfg_regs.sv
// LSU configuration registers: DCCM base, ECC chicken bit and corrected-error counter
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_cfg_regs (
   input  wire                       clk,
   input  wire                       arst_n,
   input  wire                       cfg_wr_en,
   input  wire lsu_pkg::lsu_cfg_addr_t cfg_addr,
   input  wire lsu_pkg::lsu_word_t   cfg_wdata,
   output lsu_pkg::lsu_word_t        cfg_rdata,
   input  wire                       sec_pulse,   // One corrected load in R
   output lsu_pkg::lsu_word_t        dccm_base,
   output logic                      ecc_dis
);
   import lsu_pkg::*;

   lsu_word_t sec_cnt;    // Saturates at all ones

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dccm_base <= `LSU_DCCM_BASE_RST;
         ecc_dis   <= 1'b0;
         sec_cnt   <= '0;
      end else begin
         if (cfg_wr_en && cfg_addr == `LSU_CFG_BASE_ADDR) dccm_base <= cfg_wdata;
         if (cfg_wr_en && cfg_addr == `LSU_CFG_CTRL_ADDR) ecc_dis <= cfg_wdata[0];
         // Any write clears, a clear beats a same-cycle increment
         if (cfg_wr_en && cfg_addr == `LSU_CFG_SECNT_ADDR) sec_cnt <= '0;
         else if (sec_pulse && sec_cnt != '1) sec_cnt <= sec_cnt + 32'd1;
      end
   end

   // Read side, combinational
   always_comb begin
      case (cfg_addr)
         `LSU_CFG_BASE_ADDR:  cfg_rdata = dccm_base;
         `LSU_CFG_CTRL_ADDR:  cfg_rdata = {31'b0, ecc_dis};
         `LSU_CFG_SECNT_ADDR: cfg_rdata = sec_cnt;
         default:             cfg_rdata = '0;   // Unmapped
      endcase
   end

endmodule

`default_nettype wire

//--- logic/lsu_dccm.sv
// ECC-protected DCCM: word writes with check-bit generation and a synchronous read into R
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_dccm (
   input  wire               clk,
   lsu_stage_if.snk          m,
   input  wire               ecc_dis,     // Chicken bit, store zero check bits
   output lsu_pkg::lsu_word_t rd_data,
   output lsu_pkg::lsu_ecc_t  rd_ecc
);
   import lsu_pkg::*;

   localparam int ENTRY_W = 32 + `LSU_ECC_W;   // {ecc, data}

   logic [ENTRY_W-1:0] mem [`LSU_DCCM_WORDS];

   logic     wr_en;
   logic     rd_en;
   lsu_ecc_t wr_ecc;

   // ************************************************************************
   // Access control
   // ************************************************************************
   assign wr_en  = m.valid && m.store && (m.cause == LSU_CAUSE_NONE);  // Faults never write
   assign rd_en  = m.valid && !m.store;          // Every M load reads
   assign wr_ecc = ecc_dis ? '0 : lsu_ecc_encode(m.wdata);

   // Array write and read at the edge that closes M
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[m.idx] <= {wr_ecc, m.wdata};
      end
      if (rd_en) begin
         {rd_ecc, rd_data} <= mem[m.idx];   // Held for the R stage
      end
   end

   // Index from the address stage must be known and in the array on a write
   a_wr_idx_in_range: assert property (@(posedge clk)
      wr_en |-> (!$isunknown(m.idx) && int'(m.idx) < `LSU_DCCM_WORDS));

endmodule

`default_nettype wire

//--- logic/lsu_macros.svh
// Widths, DCCM geometry and configuration register map shared by the LSU RTL and testbench
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// ***************************************************************************
// DCCM geometry
// ***************************************************************************
`define LSU_DCCM_WORDS     256           // 32-bit words in the DCCM
`define LSU_DCCM_ADDR_W    8             // Word index width
`define LSU_OFFSET_W       12            // Signed immediate offset
`define LSU_ECC_W          7             // Hamming bits plus overall parity

// ***************************************************************************
// Configuration register map
// ***************************************************************************
`define LSU_CFG_ADDR_W     4
`define LSU_CFG_BASE_ADDR  4'h0          // DCCM window base
`define LSU_CFG_CTRL_ADDR  4'h1          // Bit 0 turns ECC off
`define LSU_CFG_SECNT_ADDR 4'h2          // Corrected single-error count

// Window base out of reset
`define LSU_DCCM_BASE_RST  32'hF004_0000

`endif

//--- logic/lsu_pkg.sv
// Shared LSU types and SECDED helpers, imported by every LSU block and the testbench
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

   // ************************************************************************
   // Width types
   // ************************************************************************
   typedef logic [31:0]                   lsu_word_t;     // Data or address
   typedef logic [`LSU_OFFSET_W-1:0]      lsu_offset_t;
   typedef logic [`LSU_ECC_W-1:0]         lsu_ecc_t;      // {parity, hamming[5:0]}
   typedef logic [`LSU_DCCM_ADDR_W-1:0]   lsu_dccm_idx_t;
   typedef logic [`LSU_CFG_ADDR_W-1:0]    lsu_cfg_addr_t;

   typedef enum logic [1:0] {
      LSU_SIZE_BYTE = 2'd0,
      LSU_SIZE_HALF = 2'd1,
      LSU_SIZE_WORD = 2'd2
   } lsu_size_t;

   // Fault causes, reported with rsp_error
   typedef enum logic [1:0] {
      LSU_CAUSE_NONE       = 2'd0,
      LSU_CAUSE_MISALIGNED = 2'd1,
      LSU_CAUSE_STORE_SIZE = 2'd2,
      LSU_CAUSE_RANGE      = 2'd3
   } lsu_cause_t;

   // Hamming codeword length without the overall parity bit
   localparam int unsigned LSU_CODE_BITS = 32 + `LSU_ECC_W - 1;

   // Data bits sit at the non power-of-two positions 3..38
   function automatic lsu_ecc_t lsu_ecc_encode(input lsu_word_t data);
      lsu_ecc_t    ecc;
      int unsigned k;
      ecc = '0;
      k   = 0;
      for (int unsigned p = 1; p <= LSU_CODE_BITS; p++) begin
         if ((p & (p - 1)) != 0) begin    // Skip check-bit slots
            for (int unsigned i = 0; i < `LSU_ECC_W - 1; i++) begin
               if (p[i]) ecc[i] = ecc[i] ^ data[k];
            end
            k++;
         end
      end
      ecc[`LSU_ECC_W-1] = ^{data, ecc[`LSU_ECC_W-2:0]};  // Overall parity
      return ecc;
   endfunction

   // Low bits give the flipped position, top bit is the overall parity check
   function automatic lsu_ecc_t lsu_ecc_syndrome(input lsu_word_t data, input lsu_ecc_t ecc);
      lsu_ecc_t calc;
      calc = lsu_ecc_encode(data);
      return {^{data, ecc}, calc[`LSU_ECC_W-2:0] ^ ecc[`LSU_ECC_W-2:0]};
   endfunction

endpackage

`default_nettype wire

//--- logic/lsu_result_stage.sv
// LSU result stage: SECDED check and correction, load alignment and the registered response
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_result_stage (
   input  wire                clk,
   input  wire                arst_n,
   lsu_stage_if.snk           m,
   input  wire lsu_pkg::lsu_word_t rd_data,
   input  wire lsu_pkg::lsu_ecc_t  rd_ecc,
   input  wire                ecc_dis,
   output logic               sec_pulse,      // Corrected load, to the counter
   output logic               rsp_valid,
   output lsu_pkg::lsu_word_t rsp_data,
   output logic               rsp_error,
   output lsu_pkg::lsu_cause_t rsp_cause,
   output logic               rsp_ecc_single,
   output logic               rsp_ecc_double,
   output logic               r_busy
);
   import lsu_pkg::*;

   // R-stage descriptor
   logic       r_valid;
   logic       r_store;
   logic       r_unsigned;
   lsu_size_t  r_size;
   logic [1:0] r_off;
   lsu_cause_t r_cause;

   logic       chk_en;
   lsu_ecc_t   syn;
   logic       sec;
   logic       ded;
   logic       err_d;
   lsu_word_t  corr_data;
   lsu_word_t  shifted;
   lsu_word_t  ld_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) r_valid <= 1'b0;
      else         r_valid <= m.valid;
   end

   always_ff @(posedge clk) begin
      if (m.valid) begin
         r_store    <= m.store;
         r_unsigned <= m.unsigned_ld;
         r_size     <= m.size;
         r_off      <= m.byte_off;
         r_cause    <= m.cause;
      end
   end

   // ************************************************************************
   // SECDED check, only for clean loads with ECC on
   // ************************************************************************
   assign chk_en = r_valid && !r_store && (r_cause == LSU_CAUSE_NONE) && !ecc_dis;
   assign syn    = lsu_ecc_syndrome(rd_data, rd_ecc);
   assign sec    = chk_en && (|syn) && syn[`LSU_ECC_W-1];     // Odd parity, one flip
   assign ded    = chk_en && (|syn) && !syn[`LSU_ECC_W-1];    // Even parity, two flips

   // Flip the data bit the syndrome points at
   always_comb begin
      int unsigned k;
      corr_data = rd_data;
      k         = 0;
      for (int unsigned p = 1; p <= LSU_CODE_BITS; p++) begin
         if ((p & (p - 1)) != 0) begin
            if (sec && syn[`LSU_ECC_W-2:0] == p[`LSU_ECC_W-2:0]) corr_data[k] = ~rd_data[k];
            k++;
         end
      end
   end

   // Field extraction and extension
   assign shifted = corr_data >> {r_off, 3'b000};

   always_comb begin
      case (r_size)
         LSU_SIZE_BYTE: ld_data = {{24{!r_unsigned && shifted[7]}}, shifted[7:0]};
         LSU_SIZE_HALF: ld_data = {{16{!r_unsigned && shifted[15]}}, shifted[15:0]};
         default:       ld_data = corr_data;
      endcase
   end

   assign err_d     = (r_cause != LSU_CAUSE_NONE) || ded;   // Double error keeps cause NONE
   assign sec_pulse = sec;

   // ************************************************************************
   // Response register
   // ************************************************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp_valid      <= 1'b0;
         rsp_error      <= 1'b0;
         rsp_ecc_single <= 1'b0;
         rsp_ecc_double <= 1'b0;
      end else begin
         rsp_valid      <= r_valid;
         rsp_error      <= r_valid && err_d;
         rsp_ecc_single <= sec;
         rsp_ecc_double <= ded;
      end
   end

   always_ff @(posedge clk) begin
      if (r_valid) begin
         rsp_cause <= r_cause;
         rsp_data  <= (r_store || err_d) ? '0 : ld_data;   // Stores and errors return zero
      end
   end

   assign r_busy = r_valid;

   // Single and double classification exclude each other
   a_ecc_excl: assert property (@(posedge clk) disable iff (!arst_n)
      !(rsp_ecc_single && rsp_ecc_double));

endmodule

`default_nettype wire

//--- logic/lsu_stage_if.sv
// M-stage access descriptor, driven by the address stage and read by the DCCM and result stage
`timescale 1ns/1ps
`default_nettype none

interface lsu_stage_if;
   import lsu_pkg::*;

   logic          valid;        // Access held in M
   logic          store;
   logic          unsigned_ld;  // Zero extend sub-word loads
   lsu_size_t     size;
   logic [1:0]    byte_off;     // Address bits 1:0
   lsu_dccm_idx_t idx;          // Word index into the DCCM
   lsu_word_t     wdata;
   lsu_cause_t    cause;        // NONE for a clean access

   modport src (output valid, store, unsigned_ld, size, byte_off, idx, wdata, cause);
   modport snk (input  valid, store, unsigned_ld, size, byte_off, idx, wdata, cause);

endinterface

`default_nettype wire

//--- logic/lsu_top.sv
// LSU top level: configuration block, address and result stages and the DCCM on plain ports
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
   input  wire                       clk,
   input  wire                       arst_n,
   // Request, one per cycle
   input  wire                       req_valid,
   input  wire                       req_store,
   input  wire                       req_unsigned,
   input  wire lsu_pkg::lsu_size_t     req_size,
   input  wire lsu_pkg::lsu_word_t     req_rs1,
   input  wire lsu_pkg::lsu_word_t     req_wdata,
   input  wire lsu_pkg::lsu_offset_t   req_offset,
   // Configuration port
   input  wire                       cfg_wr_en,
   input  wire lsu_pkg::lsu_cfg_addr_t cfg_addr,
   input  wire lsu_pkg::lsu_word_t     cfg_wdata,
   output lsu_pkg::lsu_word_t        cfg_rdata,
   // Response, two cycles after the request
   output logic                      rsp_valid,
   output logic                      rsp_error,
   output logic                      rsp_ecc_single,
   output logic                      rsp_ecc_double,
   output logic                      lsu_idle,
   output lsu_pkg::lsu_word_t        rsp_data,
   output lsu_pkg::lsu_cause_t       rsp_cause
);
   import lsu_pkg::*;

   lsu_word_t dccm_base;
   logic      ecc_dis;
   logic      sec_pulse;
   lsu_word_t rd_data;     // DCCM read word into R
   lsu_ecc_t  rd_ecc;
   logic      m_busy;
   logic      r_busy;

   lsu_stage_if m_if ();   // M-stage access

   lsu_cfg_regs cfg_regs_inst (
      .clk, .arst_n, .cfg_wr_en, .cfg_addr, .cfg_wdata, .cfg_rdata,
      .sec_pulse, .dccm_base, .ecc_dis
   );

   lsu_addr_stage addr_stage_inst (
      .clk, .arst_n, .req_valid, .req_store, .req_unsigned, .req_size,
      .req_rs1, .req_wdata, .req_offset, .dccm_base,
      .m      (m_if.src),
      .m_busy
   );

   lsu_dccm dccm_inst (
      .clk,
      .m      (m_if.snk),
      .ecc_dis, .rd_data, .rd_ecc
   );

   lsu_result_stage result_stage_inst (
      .clk, .arst_n,
      .m      (m_if.snk),
      .rd_data, .rd_ecc, .ecc_dis, .sec_pulse,
      .rsp_valid, .rsp_data, .rsp_error, .rsp_cause,
      .rsp_ecc_single, .rsp_ecc_double, .r_busy
   );

   assign lsu_idle = !(m_busy || r_busy);   // Nothing in M or R

endmodule

`default_nettype wire

//--- tb/lsu_tb_model.svh
// Reference model for the LSU testbench, included in its top module after the package import
`ifndef LSU_TB_MODEL_SVH
`define LSU_TB_MODEL_SVH

// Expected response of one request
typedef struct packed {
   lsu_word_t  data;
   logic       error;
   lsu_cause_t cause;
   logic       single;     // Corrected load
   logic       dbl;        // Uncorrectable load
} exp_rsp_t;

lsu_word_t shadow_mem  [`LSU_DCCM_WORDS];   // Data of the last clean store per word
logic      shadow_zero [`LSU_DCCM_WORDS];   // Word was stored with ECC off

// ***************************************************************************
// SECDED, data bit k sits at the k-th non power-of-two codeword position
// ***************************************************************************
function automatic int ham_pos(input int k);
   int p;
   p = k + 1;
   for (int c = 1; c <= p; c = c * 2) p++;   // Step over each check slot below
   return p;
endfunction

// Hamming syndrome of a word whose check bits are all zero
function automatic logic [5:0] ham_of(input lsu_word_t d);
   logic [5:0] h;
   h = '0;
   for (int k = 0; k < 32; k++) begin
      if (d[k]) h = h ^ 6'(ham_pos(k));
   end
   return h;
endfunction

// ***************************************************************************
// Access rules
// ***************************************************************************
function automatic lsu_cause_t ref_cause(input lsu_word_t addr, input lsu_word_t base,
                                         input logic st, input lsu_size_t sz);
   if (addr - base >= 32'(4 * `LSU_DCCM_WORDS)) return LSU_CAUSE_RANGE;   // Below base wraps high
   if (st && sz != LSU_SIZE_WORD)               return LSU_CAUSE_STORE_SIZE;
   if (sz == LSU_SIZE_HALF && addr[0])          return LSU_CAUSE_MISALIGNED;
   if (sz == LSU_SIZE_WORD && addr[1:0] != 0)   return LSU_CAUSE_MISALIGNED;
   return LSU_CAUSE_NONE;
endfunction

// Loaded field, zero or sign extended
function automatic lsu_word_t ref_extract(input lsu_word_t w, input logic [1:0] off,
                                          input lsu_size_t sz, input logic uns);
   logic [7:0]  b;
   logic [15:0] h;
   b = w[8 * off +: 8];
   h = off[1] ? w[31:16] : w[15:0];
   case (sz)
      LSU_SIZE_BYTE: return uns ? {24'h0, b} : {{24{b[7]}}, b};
      LSU_SIZE_HALF: return uns ? {16'h0, h} : {{16{h[15]}}, h};
      default:       return w;
   endcase
endfunction

`endif

//--- tb/lsu_tb.sv
// Self-checking LSU testbench, drives lsu_top on the falling edge and compares responses in order
`timescale 1ns/1ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_tb;
   import lsu_pkg::*;

   `include "lsu_tb_model.svh"

   localparam int N_RAND = 160;
   localparam int N_ECC  = 24;
   localparam int N_REQ  = `LSU_DCCM_WORDS + 2 * N_RAND + 2 * N_ECC + 64;   // All requests

   logic          clk = 1'b0;
   logic          arst_n;
   logic          req_valid;
   logic          req_store;
   logic          req_unsigned;
   lsu_size_t     req_size;
   lsu_word_t     req_rs1;
   lsu_word_t     req_wdata;
   lsu_offset_t   req_offset;
   logic          cfg_wr_en;
   lsu_cfg_addr_t cfg_addr;
   lsu_word_t     cfg_wdata;
   lsu_word_t     cfg_rdata;
   logic          rsp_valid;
   logic          rsp_error;
   logic          rsp_ecc_single;
   logic          rsp_ecc_double;
   logic          lsu_idle;
   lsu_word_t     rsp_data;
   lsu_cause_t    rsp_cause;

   int            seed = 96856;
   exp_rsp_t      exp_q [$];     // Expected responses in issue order
   logic [2:0]    hist;          // req_valid at the last three edges
   lsu_word_t     cur_base;      // Window base as last written
   logic          ecc_off;
   lsu_word_t     sec_exp;       // Corrected loads since the last clear
   int            n_single;      // Single-error loads over the whole run
   int            n_double;      // Double-error loads over the whole run

   lsu_top lsu_top_inst (.*);

   always #4 clk = ~clk;

   always @(posedge clk or negedge arst_n) hist <= !arst_n ? 3'b000 : {hist[1:0], req_valid};

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "LSU testbench stopped at the first error");
   endtask

   task automatic check_word(input string name, input lsu_word_t exp, input lsu_word_t act);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_cause(input string name, input lsu_cause_t exp, input lsu_cause_t act);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t: %s expected %s got %s", $time, name,
                  exp.name(), act.name());
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
         abort_run();
      end
   endtask

   // Drive one request for a cycle and queue its expected response
   task automatic issue(input logic st, input logic uns, input lsu_size_t sz,
                        input lsu_word_t addr, input lsu_offset_t off, input lsu_word_t wd);
      exp_rsp_t      e;
      lsu_dccm_idx_t idx;
      lsu_word_t     w;
      logic [5:0]    h;
      e       = '0;
      idx     = lsu_dccm_idx_t'((addr - cur_base) >> 2);
      e.cause = ref_cause(addr, cur_base, st, sz);
      e.error = (e.cause != LSU_CAUSE_NONE);
      if (st && !e.error) begin
         shadow_mem[idx]  = wd;
         shadow_zero[idx] = ecc_off;
      end else if (!st && !e.error) begin
         w = shadow_mem[idx];
         h = ham_of(w);
         if (shadow_zero[idx] && !ecc_off && ^w) begin   // Odd parity, one bit off
            e.single = 1'b1;
            sec_exp++;
            n_single++;
            for (int k = 0; k < 32; k++) begin
               if (ham_pos(k) == int'(h)) w[k] = ~w[k];
            end
         end else if (shadow_zero[idx] && !ecc_off && h != 0) begin
            e.dbl   = 1'b1;
            e.error = 1'b1;
            n_double++;
         end
         if (!e.dbl) e.data = ref_extract(w, addr[1:0], sz, uns);
      end
      req_valid    = 1'b1;
      req_store    = st;
      req_unsigned = uns;
      req_size     = sz;
      req_rs1      = addr - 32'($signed(off));   // DUT adds the offset back
      req_offset   = off;
      req_wdata    = wd;
      exp_q.push_back(e);
      @(negedge clk);
   endtask

   // Word access in the window, or with mix any size, offset and some out of range
   task automatic random_access(input logic mix);
      logic [31:0] r;
      logic [31:0] d;
      lsu_word_t   addr;
      lsu_size_t   sz;
      r    = $random(seed);
      d    = $random(seed);
      sz   = mix ? lsu_size_t'(r[9:8] % 3) : LSU_SIZE_WORD;
      addr = cur_base + {r[7:0], 2'b00} + (mix ? r[11:10] : 2'b00);
      if (mix && r[14:12] == 3'd0) addr = addr + 32'd4096;
      issue(r[16], r[17], sz, addr, r[31:20], d);
   endtask

   task automatic cfg_write(input lsu_cfg_addr_t a, input lsu_word_t d);
      cfg_wr_en = 1'b1;
      cfg_addr  = a;
      cfg_wdata = d;
      @(negedge clk);
      cfg_wr_en = 1'b0;
   endtask

   task automatic cfg_check(input lsu_cfg_addr_t a, input lsu_word_t exp, input string name);
      cfg_addr = a;
      #1 check_word(name, exp, cfg_rdata);   // Combinational read
      @(negedge clk);
   endtask

   // Stop issuing and wait for every response
   task automatic drain();
      req_valid = 1'b0;
      while (exp_q.size() != 0) @(negedge clk);
      @(negedge clk);
   endtask

   // ************************************************************************
   // Compare, one response two edges after each request
   // ************************************************************************
   always @(negedge clk) begin : compare
      exp_rsp_t e;
      if (arst_n) begin
         check_bit("lsu_idle", !(hist[0] || hist[1]), lsu_idle);
         check_bit("rsp_valid", hist[2], rsp_valid);
         if (rsp_valid && exp_q.size() != 0) begin
            e = exp_q.pop_front();
            check_word("rsp_data", e.data, rsp_data);
            check_bit("rsp_error", e.error, rsp_error);
            check_cause("rsp_cause", e.cause, rsp_cause);
            check_bit("rsp_ecc_single", e.single, rsp_ecc_single);
            check_bit("rsp_ecc_double", e.dbl, rsp_ecc_double);
         end
      end
   end

   // One request per 8 ns cycle plus reset, drain and configuration margin
   initial begin
      #((N_REQ + 400) * 8);
      $display("Watchdog timeout, the LSU stopped answering requests");
      abort_run();
   end

   initial begin
      arst_n       = 1'b0;
      req_valid    = 1'b0;
      req_store    = 1'b0;
      req_unsigned = 1'b0;
      req_size     = LSU_SIZE_WORD;
      req_rs1      = '0;
      req_wdata    = '0;
      req_offset   = '0;
      cfg_wr_en    = 1'b0;
      cfg_addr     = '0;
      cfg_wdata    = '0;
      cur_base     = `LSU_DCCM_BASE_RST;
      ecc_off      = 1'b0;
      sec_exp      = '0;
      n_single     = 0;
      n_double     = 0;
      repeat (4) @(negedge clk);
      arst_n = 1'b1;
      cfg_check(`LSU_CFG_BASE_ADDR, `LSU_DCCM_BASE_RST, "cfg_rdata base");
      cfg_check(`LSU_CFG_SECNT_ADDR, '0, "cfg_rdata secnt");
      cfg_check(4'hF, '0, "cfg_rdata unmapped");
      for (int i = 0; i < `LSU_DCCM_WORDS; i++) begin   // Fill from the word index
         issue(1'b1, 1'b0, LSU_SIZE_WORD, cur_base + 4 * i, 12'(-4 * (i % 8)),
               32'h9E37_79B9 * (i + 1));
      end
      repeat (N_RAND) random_access(1'b0);
      // Sub-word loads, both extensions at every legal offset
      issue(1'b1, 1'b0, LSU_SIZE_WORD, cur_base, '0, 32'h80FF_7F01);
      issue(1'b1, 1'b0, LSU_SIZE_WORD, cur_base + 4, '0, 32'h7F80_01FE);
      for (int j = 0; j < 32; j++) begin
         issue(1'b0, j[0], j[4] ? LSU_SIZE_HALF : LSU_SIZE_BYTE,
               cur_base + {j[3], (j[4] ? {j[2], 1'b0} : j[2:1])}, '0, '0);
      end
      // Move the window, then each fault class
      drain();
      cur_base = 32'h2000_0000;
      cfg_write(`LSU_CFG_BASE_ADDR, cur_base);
      cfg_check(`LSU_CFG_BASE_ADDR, cur_base, "cfg_rdata base");
      issue(1'b0, 1'b0, LSU_SIZE_WORD, `LSU_DCCM_BASE_RST, '0, '0);     // Old window
      issue(1'b0, 1'b0, LSU_SIZE_WORD, cur_base - 4, '0, '0);
      issue(1'b1, 1'b0, LSU_SIZE_WORD, cur_base + 1024, '0, 32'hDEAD_BEEF);
      issue(1'b1, 1'b0, LSU_SIZE_HALF, cur_base + 8, '0, 32'h1111_1111);
      issue(1'b1, 1'b0, LSU_SIZE_BYTE, cur_base + 13, '0, 32'h2222_2222);
      issue(1'b1, 1'b0, LSU_SIZE_WORD, cur_base + 18, '0, 32'h3333_3333);
      issue(1'b0, 1'b0, LSU_SIZE_HALF, cur_base + 7, '0, '0);
      issue(1'b0, 1'b0, LSU_SIZE_WORD, cur_base + 6, '0, '0);
      issue(1'b0, 1'b0, LSU_SIZE_WORD, cur_base + 1020, '0, '0);     // Last word
      for (int i = 0; i < 6; i++) issue(1'b0, 1'b0, LSU_SIZE_WORD, cur_base + 4 * i, '0, '0);
      // ECC off stores zero check bits, loads with ECC on classify them
      drain();
      ecc_off = 1'b1;
      cfg_write(`LSU_CFG_CTRL_ADDR, 32'd1);
      cfg_check(`LSU_CFG_CTRL_ADDR, 32'd1, "cfg_rdata ctrl");
      for (int i = 0; i < N_ECC; i++) begin
         issue(1'b1, 1'b0, LSU_SIZE_WORD, cur_base + 400 + 4 * i, '0, $random(seed));
      end
      drain();
      ecc_off = 1'b0;
      cfg_write(`LSU_CFG_CTRL_ADDR, 32'd0);
      cfg_check(`LSU_CFG_CTRL_ADDR, '0, "cfg_rdata ctrl");
      for (int i = 0; i < N_ECC; i++) begin
         issue(1'b0, 1'b0, LSU_SIZE_WORD, cur_base + 400 + 4 * i, '0, '0);
      end
      issue(1'b0, 1'b1, LSU_SIZE_BYTE, cur_base + 401, '0, '0);
      drain();
      cfg_check(`LSU_CFG_SECNT_ADDR, sec_exp, "cfg_rdata secnt");
      cfg_write(`LSU_CFG_SECNT_ADDR, 32'h1);   // Any write clears
      sec_exp = '0;
      cfg_check(`LSU_CFG_SECNT_ADDR, sec_exp, "cfg_rdata secnt");
      repeat (N_RAND) random_access(1'b1);     // Back-to-back mixed burst
      drain();
      check_bit("lsu_idle", 1'b1, lsu_idle);
      if (n_single == 0 || n_double == 0) begin
         $display("ECC loads did not produce both a single and a double error");
         abort_run();
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire
